/* sim.f */
hdl/stream_pkg.sv
hdl/status_pkg.sv
hdl/status_gen.sv
hdl/axis_ex_status.sv
hdl/axis_fifo.sv
hdl/packet_status_tagger.sv
verif/tb_packet_status_tagger.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the packet status tagger testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

TOP=tb_packet_status_tagger
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f sim.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi

exit 0

/* verif/tb_packet_status_tagger.sv */
// Testbench for the packet status tagger.
// Random packets with random gaps and back-pressure, a queue-based
// reference model of the status word, and a stall stability monitor.

`timescale 1ns/1ps

module tb_packet_status_tagger
    import stream_pkg::*, status_pkg::*;
();

    localparam int          CLK_PERIOD_NS = 20;
    localparam int          NUM_PACKETS   = 200;
    localparam int          MAX_PKT_BEATS = 16;
    localparam int          WATCHDOG_NS   = NUM_PACKETS * MAX_PKT_BEATS * 40 * CLK_PERIOD_NS;
    localparam logic [31:0] RAND_SEED     = 32'hf571_a90f;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        logic [USER_WIDTH-1:0]   user;
        logic [STATUS_WIDTH-1:0] status;
    } beat_rec_t;

    logic                  clock = 1'b0;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] s_tdata;
    logic [DATA_BYTES-1:0] s_tkeep;
    logic                  s_tlast;
    logic [USER_WIDTH-1:0] s_tuser;
    logic                  s_tvalid;
    logic                  s_tready;
    logic [DATA_WIDTH-1:0] m_tdata;
    logic [DATA_BYTES-1:0] m_tkeep;
    logic                  m_tlast;
    logic [USER_WIDTH-1:0] m_tuser;
    logic                  m_tvalid;
    status_word_u          m_status;
    logic                  m_tready;

    beat_rec_t   exp_q[$];
    beat_rec_t   held_rec;
    bit          stall_pending = 1'b0;
    int          errors        = 0;
    int          in_count      = 0;
    int          out_count     = 0;
    int          exp_index     = 0;
    int          exp_bytes     = 0;
    logic [7:0]  exp_csum      = '0;

    packet_status_tagger DUT (
        .clock    (clock),
        .rst_n    (rst_n),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tvalid (m_tvalid),
        .m_status (m_status),
        .m_tready (m_tready)
    );

    always #(CLK_PERIOD_NS / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    // ########################################################################
    // Reference model
    // ########################################################################

    // Status word straight from the field rules of the two views.
    task automatic model_accept();
        beat_rec_t  rec;
        int         beat_bytes;
        logic [7:0] beat_csum;
        beat_bytes = 0;
        beat_csum  = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (s_tkeep[i]) begin
                beat_bytes++;
                beat_csum = beat_csum ^ s_tdata[i*8 +: 8];
            end
        end
        rec        = '0;
        rec.data   = s_tdata;
        rec.keep   = s_tkeep;
        rec.last   = s_tlast;
        rec.user   = s_tuser;
        if (s_tlast) begin
            rec.status[STATUS_WIDTH-1]                    = 1'b1;
            rec.status[CHECKSUM_WIDTH +: BYTE_COUNT_WIDTH] =
                BYTE_COUNT_WIDTH'(exp_bytes + beat_bytes);
            rec.status[0 +: CHECKSUM_WIDTH]                = exp_csum ^ beat_csum;
            exp_index = 0;
            exp_bytes = 0;
            exp_csum  = '0;
        end else begin
            rec.status[0 +: BEAT_INDEX_WIDTH] = BEAT_INDEX_WIDTH'(exp_index);
            exp_index++;
            exp_bytes = exp_bytes + beat_bytes;
            exp_csum  = exp_csum ^ beat_csum;
        end
        exp_q.push_back(rec);
        in_count++;
    endtask

    task automatic compare_output();
        beat_rec_t exp;
        out_count++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Output beat at %0t has no matching input beat", $time);
        end else begin
            exp = exp_q.pop_front();
            check_value("order_data", 64'(exp.data), 64'(m_tdata));
            check_value("order_keep", 64'(exp.keep), 64'(m_tkeep));
            check_value("order_last", 64'(exp.last), 64'(m_tlast));
            check_value("order_user", 64'(exp.user), 64'(m_tuser));
            check_value("is_summary", 64'(exp.status[STATUS_WIDTH-1]),
                        64'(m_status.beat.is_summary));
            if (exp.last) begin
                check_value("summary_byte_count",
                            64'(exp.status[CHECKSUM_WIDTH +: BYTE_COUNT_WIDTH]),
                            64'(m_status.summary.byte_count));
                check_value("summary_checksum", 64'(exp.status[0 +: CHECKSUM_WIDTH]),
                            64'(m_status.summary.checksum));
            end else begin
                check_value("beat_index", 64'(exp.status[0 +: BEAT_INDEX_WIDTH]),
                            64'(m_status.beat.beat_index));
            end
            // Whole word as well, so reserved bits are covered.
            check_value("status_word", 64'(exp.status), 64'(m_status));
        end
    endtask

    // Everything is sampled mid-cycle, away from the edges that drive it.
    always @(negedge clock) begin : monitor
        beat_rec_t cur;
        if (rst_n) begin
            if (s_tvalid && s_tready) begin
                model_accept();
            end
            cur = {m_tdata, m_tkeep, m_tlast, m_tuser, m_status};
            if (stall_pending) begin
                check_value("stall_valid", 64'(1), 64'(m_tvalid));
                check_value("stall_payload", 64'(held_rec), 64'(cur));
            end
            if (m_tvalid && m_tready) begin
                compare_output();
            end
            stall_pending = m_tvalid && !m_tready;
            held_rec      = cur;
        end
    end

    // ########################################################################
    // Source and sink
    // ########################################################################

    // Called right after a rising edge; returns after the edge that took the beat.
    task automatic send_beat(input logic [DATA_WIDTH-1:0] data,
                             input logic [DATA_BYTES-1:0] keep, input logic last);
        bit accepted;
        accepted = 1'b0;
        s_tdata  <= data;
        s_tkeep  <= keep;
        s_tlast  <= last;
        s_tuser  <= USER_WIDTH'($urandom_range(0, 1));
        s_tvalid <= 1'b1;
        while (!accepted) begin
            @(negedge clock);
            accepted = s_tready;
            @(posedge clock);
        end
    endtask

    task automatic idle_gap();
        int cycles;
        cycles = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 4)) : 0;
        if (cycles > 0) begin
            s_tvalid <= 1'b0;
            repeat (cycles) @(posedge clock);
        end
    endtask

    task automatic send_packet();
        int                    beats;
        logic [DATA_BYTES-1:0] last_keep;
        beats     = int'($urandom_range(1, MAX_PKT_BEATS));
        last_keep = DATA_BYTES'((1 << $urandom_range(1, DATA_BYTES)) - 1);
        for (int b = 0; b < beats; b++) begin
            idle_gap();
            if (b == beats - 1) begin
                send_beat(DATA_WIDTH'($urandom()), last_keep, 1'b1);
            end else begin
                send_beat(DATA_WIDTH'($urandom()), '1, 1'b0);
            end
        end
    endtask

    initial begin : sink
        @(posedge rst_n);
        forever begin
            @(posedge clock);
            m_tready <= ($urandom_range(0, 99) < 60);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors: %0d, beats in: %0d, beats out: %0d", errors + 1, in_count, out_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main_seq
        void'($urandom(RAND_SEED));
        rst_n    <= 1'b0;
        s_tdata  <= '0;
        s_tkeep  <= '0;
        s_tlast  <= 1'b0;
        s_tuser  <= '0;
        s_tvalid <= 1'b0;
        m_tready <= 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // Idle state right after reset.
        @(negedge clock);
        check_value("reset_m_tvalid", 64'(0), 64'(m_tvalid));
        check_value("reset_m_status", 64'(0), 64'(m_status));
        check_value("reset_s_tready", 64'(1), 64'(s_tready));

        @(posedge clock);
        for (int p = 0; p < NUM_PACKETS; p++) begin
            send_packet();
        end
        s_tvalid <= 1'b0;

        wait (out_count == in_count);
        repeat (4) @(negedge clock);
        check_value("drain_m_tvalid", 64'(0), 64'(m_tvalid));
        check_value("queue_empty", 64'(0), 64'(exp_q.size()));
        check_value("beats_delivered", 64'(in_count), 64'(out_count));

        $display("Errors: %0d, beats in: %0d, beats out: %0d", errors, in_count, out_count);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/packet_status_tagger.sv */
// Packet status tagger top level.
// Status generator, register slice and output FIFO wired in a chain.

`timescale 1ns/1ps

module packet_status_tagger
    import stream_pkg::*, status_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic [DATA_BYTES-1:0] s_tkeep,
    input  logic                  s_tlast,
    input  logic [USER_WIDTH-1:0] s_tuser,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic [DATA_BYTES-1:0] m_tkeep,
    output logic                  m_tlast,
    output logic [USER_WIDTH-1:0] m_tuser,
    output logic                  m_tvalid,
    output status_word_u          m_status,
    input  logic                  m_tready
);

    status_word_u          gen_status;
    status_word_u          slice_status;
    logic [DATA_WIDTH-1:0] slice_tdata;
    logic [DATA_BYTES-1:0] slice_tkeep;
    logic                  slice_tlast;
    logic [USER_WIDTH-1:0] slice_tuser;
    logic                  slice_tvalid;
    logic                  slice_tready;

    // Status for the beat waiting at the input port.
    status_gen u_status_gen (
        .clock         (clock),
        .rst_n         (rst_n),
        .s_tdata       (s_tdata),
        .s_tkeep       (s_tkeep),
        .s_tlast       (s_tlast),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .origin_status (gen_status)
    );

    // Binds the status to its beat; input ready follows the FIFO.
    axis_ex_status u_axis_ex_status (
        .clock          (clock),
        .rst_n          (rst_n),
        .origin_status  (gen_status),
        .binding_status (slice_status),
        .s_tdata        (s_tdata),
        .s_tkeep        (s_tkeep),
        .s_tlast        (s_tlast),
        .s_tuser        (s_tuser),
        .s_tvalid       (s_tvalid),
        .s_tready       (s_tready),
        .m_tdata        (slice_tdata),
        .m_tkeep        (slice_tkeep),
        .m_tlast        (slice_tlast),
        .m_tuser        (slice_tuser),
        .m_tvalid       (slice_tvalid),
        .m_tready       (slice_tready)
    );

    axis_fifo u_axis_fifo (
        .clock    (clock),
        .rst_n    (rst_n),
        .s_tdata  (slice_tdata),
        .s_tkeep  (slice_tkeep),
        .s_tlast  (slice_tlast),
        .s_tuser  (slice_tuser),
        .s_status (slice_status),
        .s_tvalid (slice_tvalid),
        .s_tready (slice_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_status (m_status),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

endmodule

/* hdl/axis_fifo.sv */
// Small synchronous FIFO for AXI-stream beats plus their status word.
// Register array storage, read and write pointers, occupancy count.

`timescale 1ns/1ps

module axis_fifo
    import stream_pkg::*, status_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic [DATA_BYTES-1:0] s_tkeep,
    input  logic                  s_tlast,
    input  logic [USER_WIDTH-1:0] s_tuser,
    input  status_word_u          s_status,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic [DATA_BYTES-1:0] m_tkeep,
    output logic                  m_tlast,
    output logic [USER_WIDTH-1:0] m_tuser,
    output status_word_u          m_status,
    output logic                  m_tvalid,
    input  logic                  m_tready
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] data_mem   [FIFO_DEPTH];
    logic [DATA_BYTES-1:0] keep_mem   [FIFO_DEPTH];
    logic                  last_mem   [FIFO_DEPTH];
    logic [USER_WIDTH-1:0] user_mem   [FIFO_DEPTH];
    status_word_u          status_mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [CNT_WIDTH-1:0]  count;
    logic                  wr_en;
    logic                  rd_en;

    assign s_tready = (count != CNT_WIDTH'(FIFO_DEPTH));
    assign m_tvalid = (count != '0);
    assign wr_en    = s_tvalid && s_tready;
    assign rd_en    = m_tvalid && m_tready;

    // The head entry is always on the output.
    assign m_tdata  = data_mem[rd_ptr];
    assign m_tkeep  = keep_mem[rd_ptr];
    assign m_tlast  = last_mem[rd_ptr];
    assign m_tuser  = user_mem[rd_ptr];
    assign m_status = status_mem[rd_ptr];

    // ########################################################################
    // Storage
    // ########################################################################

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                data_mem[i]   <= '0;
                keep_mem[i]   <= '0;
                last_mem[i]   <= 1'b0;
                user_mem[i]   <= '0;
                status_mem[i] <= '0;
            end
        end else if (wr_en) begin
            data_mem[wr_ptr]   <= s_tdata;
            keep_mem[wr_ptr]   <= s_tkeep;
            last_mem[wr_ptr]   <= s_tlast;
            user_mem[wr_ptr]   <= s_tuser;
            status_mem[wr_ptr] <= s_status;
        end
    end

    // ########################################################################
    // Pointers and occupancy
    // ########################################################################

    // A write and a read on the same edge leave the count unchanged.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_WIDTH'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_WIDTH'(1);
            end
            if (wr_en && !rd_en) begin
                count <= count + CNT_WIDTH'(1);
            end else if (rd_en && !wr_en) begin
                count <= count - CNT_WIDTH'(1);
            end
        end
    end

endmodule

/* hdl/axis_ex_status.sv */
// One-stage AXI-stream register slice.
// Captures a beat together with its status word so both leave in the
// same cycle, and holds them until the downstream handshake.

`timescale 1ns/1ps

module axis_ex_status
    import stream_pkg::*, status_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  status_word_u          origin_status,
    output status_word_u          binding_status,
    // Upstream side.
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic [DATA_BYTES-1:0] s_tkeep,
    input  logic                  s_tlast,
    input  logic [USER_WIDTH-1:0] s_tuser,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    // Downstream side.
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic [DATA_BYTES-1:0] m_tkeep,
    output logic                  m_tlast,
    output logic [USER_WIDTH-1:0] m_tuser,
    output logic                  m_tvalid,
    input  logic                  m_tready
);

    logic in_xfer;
    logic out_xfer;

    // Ready comes straight from downstream, so a new beat is only taken
    // when the held one can leave on the same edge.
    assign s_tready = m_tready;

    assign in_xfer  = s_tvalid && s_tready;
    assign out_xfer = m_tvalid && m_tready;

    // ########################################################################
    // Valid flag
    // ########################################################################

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid <= 1'b0;
        end else if (in_xfer) begin
            m_tvalid <= 1'b1;
        end else if (out_xfer) begin
            m_tvalid <= 1'b0;
        end
    end

    // ########################################################################
    // Beat and status
    // ########################################################################

    // A beat that leaves with nothing behind it leaves zeros in the stage.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_tdata        <= '0;
            m_tkeep        <= '0;
            m_tlast        <= 1'b0;
            m_tuser        <= '0;
            binding_status <= '0;
        end else if (in_xfer) begin
            m_tdata        <= s_tdata;
            m_tkeep        <= s_tkeep;
            m_tlast        <= s_tlast;
            m_tuser        <= s_tuser;
            binding_status <= origin_status;
        end else if (out_xfer) begin
            m_tdata        <= '0;
            m_tkeep        <= '0;
            m_tlast        <= 1'b0;
            m_tuser        <= '0;
            binding_status <= '0;
        end
    end

endmodule

/* hdl/status_gen.sv */
// Status word generator.
// Tracks beat index, byte count and XOR checksum of the open packet and
// builds the status word for the beat that is presented right now.

`timescale 1ns/1ps

module status_gen
    import stream_pkg::*, status_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic [DATA_BYTES-1:0] s_tkeep,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    input  logic                  s_tready,
    output status_word_u          origin_status
);

    logic [BEAT_CNT_WIDTH-1:0]   beat_cnt;
    logic [BYTE_COUNT_WIDTH-1:0] byte_total;
    logic [CHECKSUM_WIDTH-1:0]   csum_total;
    logic [KEEP_CNT_WIDTH-1:0]   beat_bytes;
    logic [CHECKSUM_WIDTH-1:0]   beat_csum;
    logic [BYTE_COUNT_WIDTH-1:0] byte_next;
    logic [CHECKSUM_WIDTH-1:0]   csum_next;
    logic                        in_xfer;

    assign in_xfer = s_tvalid && s_tready;

    // ########################################################################
    // Contribution of the current beat
    // ########################################################################

    always_comb begin : beat_fold
        beat_bytes = '0;
        beat_csum  = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (s_tkeep[i]) begin
                beat_bytes = beat_bytes + KEEP_CNT_WIDTH'(1);
                beat_csum  = beat_csum ^ s_tdata[i*8 +: 8];
            end
        end
    end

    // Packet totals including this beat, used by the summary view.
    assign byte_next = byte_total + BYTE_COUNT_WIDTH'(beat_bytes);
    assign csum_next = csum_total ^ beat_csum;

    // ########################################################################
    // Status word for the presented beat
    // ########################################################################

    always_comb begin : status_build
        origin_status = '0;
        if (s_tlast) begin
            origin_status.summary.is_summary = 1'b1;
            origin_status.summary.byte_count = byte_next;
            origin_status.summary.checksum   = csum_next;
        end else begin
            origin_status.beat.is_summary = 1'b0;
            origin_status.beat.beat_index = BEAT_INDEX_WIDTH'(beat_cnt);
        end
    end

    // ########################################################################
    // Running packet state
    // ########################################################################

    // The totals move only on a transfer and start over after the last beat.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            byte_total <= '0;
            csum_total <= '0;
        end else if (in_xfer) begin
            if (s_tlast) begin
                beat_cnt   <= '0;
                byte_total <= '0;
                csum_total <= '0;
            end else begin
                beat_cnt   <= beat_cnt + BEAT_CNT_WIDTH'(1);
                byte_total <= byte_next;
                csum_total <= csum_next;
            end
        end
    end

endmodule

/* hdl/status_pkg.sv */
// Status word carried next to every beat.
// Field widths, the beat view, the summary view and their union.

package status_pkg;

    localparam int STATUS_WIDTH     = 24;
    localparam int BEAT_INDEX_WIDTH = 12;
    localparam int BYTE_COUNT_WIDTH = 11;
    localparam int CHECKSUM_WIDTH   = 8;

    // Beats that are not last carry their index within the packet.
    typedef struct packed {
        logic                                       is_summary;
        logic [STATUS_WIDTH-1-BEAT_INDEX_WIDTH-1:0] reserved;
        logic [BEAT_INDEX_WIDTH-1:0]                beat_index;
    } beat_status_t;

    // The last beat carries the summary of the whole packet.
    typedef struct packed {
        logic                                                      is_summary;
        logic [STATUS_WIDTH-1-BYTE_COUNT_WIDTH-CHECKSUM_WIDTH-1:0] reserved;
        logic [BYTE_COUNT_WIDTH-1:0]                               byte_count;
        logic [CHECKSUM_WIDTH-1:0]                                 checksum;
    } summary_status_t;

    // The top bit, is_summary, tells which view applies.
    typedef union packed {
        beat_status_t    beat;
        summary_status_t summary;
    } status_word_u;

endpackage

/* hdl/stream_pkg.sv */
// Stream geometry for the packet status tagger.
// Beat width, side-band width, FIFO depth and the packet length limit.

package stream_pkg;

    // ########################################################################
    // Beat geometry
    // ########################################################################

    // Bytes carried by one beat, and the matching tdata width.
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = DATA_BYTES * 8;

    // Width of a count of set keep bits in one beat (0 to DATA_BYTES).
    localparam int KEEP_CNT_WIDTH = $clog2(DATA_BYTES + 1);

    // Source error flag, carried through untouched.
    localparam int USER_WIDTH = 1;

    // ########################################################################
    // Buffering and packet limits
    // ########################################################################

    localparam int FIFO_DEPTH = 4;

    // Longest packet the path has to count through.
    localparam int MAX_BEATS      = 256;
    localparam int BEAT_CNT_WIDTH = $clog2(MAX_BEATS);

endpackage
